// File: logic/arm_pkg.sv
package arm_pkg;

	localparam int DATA_W = 32;
	// 256 words of unified memory by default
	localparam int ADDR_W = 8;
	localparam int REG_COUNT = 16;

	typedef enum logic [1:0] {
		MODE_ARITH  = 2'b00,
		MODE_MEMORY = 2'b01,
		MODE_BRANCH = 2'b10,
		MODE_HALT   = 2'b11
	} mode_e;

	// Data-processing opcodes in ARM numbering
	typedef enum logic [3:0] {
		OP_AND = 4'b0000,
		OP_EOR = 4'b0001,
		OP_SUB = 4'b0010,
		OP_ADD = 4'b0100,
		OP_ADC = 4'b0101,
		OP_SBC = 4'b0110,
		OP_TST = 4'b1000,
		OP_CMP = 4'b1010,
		OP_ORR = 4'b1100,
		OP_MOV = 4'b1101,
		OP_MVN = 4'b1111
	} opcode_e;

	// CMP runs as SUB and TST as AND, loads and stores as ADD
	typedef enum logic [3:0] {
		EXE_NOP = 4'b0000,
		EXE_MOV = 4'b0001,
		EXE_ADD = 4'b0010,
		EXE_ADC = 4'b0011,
		EXE_SUB = 4'b0100,
		EXE_SBC = 4'b0101,
		EXE_AND = 4'b0110,
		EXE_ORR = 4'b0111,
		EXE_EOR = 4'b1000,
		EXE_MVN = 4'b1001
	} exe_cmd_e;

	typedef union packed {
		struct packed {
			logic [3:0] cond;
			mode_e mode;
			logic imm;
			opcode_e opcode;
			logic s;
			logic [3:0] rn;
			logic [3:0] rd;
			logic [11:0] op2;
		} dp;
		struct packed {
			logic [3:0] cond;
			mode_e mode;
			logic [1:0] pad;
			logic signed [23:0] offset;
		} br;
	} instr_u;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

endpackage

// File: logic/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import arm_pkg::*; #(
	parameter int ADDR_W = arm_pkg::ADDR_W
) ();
	logic req;
	logic we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic gnt;
	logic rvalid;
	logic [DATA_W-1:0] rdata;

	// Requester side holds its request until gnt
	modport master (output req, we, addr, wdata, input gnt, rvalid, rdata);
	modport slave (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import arm_pkg::*; (
	input instr_u instr,
	output exe_cmd_e exe_cmd,
	output logic immediate,
	output logic mem_read,
	output logic mem_write,
	output logic wb_enable,
	output logic branch_taken,
	output logic status_write_enable
);

	always_comb begin
		exe_cmd = EXE_NOP;
		immediate = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		wb_enable = 1'b0;
		branch_taken = 1'b0;
		status_write_enable = 1'b0;
		case (instr.dp.mode)
			MODE_ARITH: begin
				immediate = instr.dp.imm;
				wb_enable = 1'b1;
				status_write_enable = instr.dp.s;
				case (instr.dp.opcode)
					OP_MOV: exe_cmd = EXE_MOV;
					OP_MVN: exe_cmd = EXE_MVN;
					OP_ADD: exe_cmd = EXE_ADD;
					OP_ADC: exe_cmd = EXE_ADC;
					OP_SUB: exe_cmd = EXE_SUB;
					OP_SBC: exe_cmd = EXE_SBC;
					OP_AND: exe_cmd = EXE_AND;
					OP_ORR: exe_cmd = EXE_ORR;
					OP_EOR: exe_cmd = EXE_EOR;
					OP_CMP: begin
						exe_cmd = EXE_SUB;
						wb_enable = 1'b0;
						status_write_enable = 1'b1;
					end
					OP_TST: begin
						exe_cmd = EXE_AND;
						wb_enable = 1'b0;
						status_write_enable = 1'b1;
					end
					default: wb_enable = 1'b0;
				endcase
			end
			MODE_MEMORY: begin
				// Address is base plus offset, S picks load over store
				exe_cmd = EXE_ADD;
				immediate = instr.dp.imm;
				mem_read = instr.dp.s;
				mem_write = !instr.dp.s;
				wb_enable = instr.dp.s;
			end
			MODE_BRANCH: branch_taken = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import arm_pkg::*; (
	input logic clk,
	input logic rst_n,
	input exe_cmd_e exe_cmd,
	input logic [DATA_W-1:0] op_a,
	input logic [DATA_W-1:0] op_b,
	input logic flag_we,
	output logic [DATA_W-1:0] result,
	output flags_t flags
);

	logic [DATA_W-1:0] add_b;
	logic carry_in;
	logic [DATA_W:0] sum;
	logic arith;
	flags_t next_flags;

	always_comb begin
		add_b = op_b;
		carry_in = 1'b0;
		arith = 1'b0;
		case (exe_cmd)
			EXE_ADD: arith = 1'b1;
			EXE_ADC: begin
				arith = 1'b1;
				carry_in = flags.c;
			end
			// Subtract as a + ~b + 1, so C comes out as the inverted borrow
			EXE_SUB: begin
				arith = 1'b1;
				add_b = ~op_b;
				carry_in = 1'b1;
			end
			EXE_SBC: begin
				arith = 1'b1;
				add_b = ~op_b;
				carry_in = flags.c;
			end
			default: ;
		endcase
		sum = {1'b0, op_a} + {1'b0, add_b} + {{DATA_W{1'b0}}, carry_in};
		case (exe_cmd)
			EXE_MOV: result = op_b;
			EXE_MVN: result = ~op_b;
			EXE_AND: result = op_a & op_b;
			EXE_ORR: result = op_a | op_b;
			EXE_EOR: result = op_a ^ op_b;
			default: result = sum[DATA_W-1:0];
		endcase
		next_flags = flags;
		next_flags.n = result[DATA_W-1];
		next_flags.z = (result == '0);
		if (arith) begin
			next_flags.c = sum[DATA_W];
			next_flags.v = (op_a[DATA_W-1] == add_b[DATA_W-1]) &&
				(sum[DATA_W-1] != op_a[DATA_W-1]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			flags <= '0;
		else if (flag_we)
			flags <= next_flags;
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file import arm_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [3:0] rs_a,
	input logic [3:0] rs_b,
	input logic [3:0] rd,
	input logic we,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata_a,
	output logic [DATA_W-1:0] rdata_b
);

	logic [DATA_W-1:0] regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rd] <= wdata;
		end
	end

	// No bypass, a read in the write cycle sees the old value
	assign rdata_a = regs[rs_a];
	assign rdata_b = regs[rs_b];

endmodule

// File: logic/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer import arm_pkg::*; #(
	parameter int ADDR_W = arm_pkg::ADDR_W
) (
	input logic clk,
	input logic rst_n,
	input logic run,
	mem_bus_if.master bus,
	output instr_u instr,
	input logic mem_read,
	input logic mem_write,
	input logic wb_enable,
	input logic branch_taken,
	input logic status_write_enable,
	output logic lsu_start,
	input logic lsu_done,
	output logic wb_sel_load,
	output logic reg_we,
	output logic flag_we,
	output logic halted
);

	typedef enum logic [2:0] {IDLE, FETCH, WAIT_INSTR, EXECUTE, MEMORY, HALT} state_e;

	state_e state;
	logic [ADDR_W-1:0] pc;
	logic is_mem;
	logic is_halt;

	assign is_mem = mem_read || mem_write;
	assign is_halt = (instr.dp.mode == MODE_HALT);

	// Fetch port is read only
	assign bus.req = (state == FETCH);
	assign bus.we = 1'b0;
	assign bus.addr = pc;
	assign bus.wdata = '0;

	assign lsu_start = (state == EXECUTE) && is_mem;
	assign wb_sel_load = (state == MEMORY);
	assign reg_we = ((state == EXECUTE) && wb_enable && !is_mem) ||
		((state == MEMORY) && lsu_done && mem_read);
	assign flag_we = (state == EXECUTE) && status_write_enable;
	assign halted = (state == HALT);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			pc <= '0;
		end else begin
			case (state)
				IDLE: if (run) state <= FETCH;
				FETCH: if (bus.gnt) state <= WAIT_INSTR;
				WAIT_INSTR: if (bus.rvalid) state <= EXECUTE;
				EXECUTE: begin
					if (is_halt) begin
						state <= HALT;
					end else begin
						// Branch offset counts words from the next instruction
						if (branch_taken)
							pc <= pc + 1'b1 + ADDR_W'(instr.br.offset);
						else
							pc <= pc + 1'b1;
						state <= is_mem ? MEMORY : FETCH;
					end
				end
				MEMORY: if (lsu_done) state <= FETCH;
				HALT: begin
					if (!run) begin
						state <= IDLE;
						pc <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT_INSTR && bus.rvalid)
			instr <= instr_u'(bus.rdata);
	end

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import arm_pkg::*; #(
	parameter int ADDR_W = arm_pkg::ADDR_W
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic is_load,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] store_data,
	mem_bus_if.master bus,
	output logic done,
	output logic [DATA_W-1:0] load_data
);

	logic busy;
	logic wait_rd;
	logic is_load_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] data_q;
	logic [DATA_W-1:0] load_q;

	assign bus.req = busy;
	assign bus.we = !is_load_q;
	assign bus.addr = addr_q;
	assign bus.wdata = data_q;

	// Store finishes at its grant, load when the word comes back
	assign done = (busy && bus.gnt && !is_load_q) || (wait_rd && bus.rvalid);
	assign load_data = (wait_rd && bus.rvalid) ? bus.rdata : load_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			wait_rd <= 1'b0;
		end else begin
			if (start)
				busy <= 1'b1;
			else if (busy && bus.gnt)
				busy <= 1'b0;
			if (busy && bus.gnt)
				wait_rd <= is_load_q;
			else if (bus.rvalid)
				wait_rd <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			is_load_q <= is_load;
			addr_q <= addr;
			data_q <= store_data;
		end
		if (wait_rd && bus.rvalid)
			load_q <= bus.rdata;
	end

endmodule

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import arm_pkg::*; #(
	parameter int ADDR_W = arm_pkg::ADDR_W
) (
	input logic clk,
	input logic rst_n,
	mem_bus_if.slave host,
	mem_bus_if.slave lsu,
	mem_bus_if.slave fetch,
	output logic mem_en,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	input logic [DATA_W-1:0] mem_rdata
);

	logic rd_host;
	logic rd_lsu;
	logic rd_fetch;

	// Host first, then load/store, then fetch
	assign host.gnt = host.req;
	assign lsu.gnt = lsu.req && !host.req;
	assign fetch.gnt = fetch.req && !host.req && !lsu.req;

	assign mem_en = host.req || lsu.req || fetch.req;

	always_comb begin
		if (host.req) begin
			mem_we = host.we;
			mem_addr = host.addr;
			mem_wdata = host.wdata;
		end else if (lsu.req) begin
			mem_we = lsu.we;
			mem_addr = lsu.addr;
			mem_wdata = lsu.wdata;
		end else begin
			mem_we = fetch.we;
			mem_addr = fetch.addr;
			mem_wdata = fetch.wdata;
		end
	end

	// Owner of the read issued last cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_host <= 1'b0;
			rd_lsu <= 1'b0;
			rd_fetch <= 1'b0;
		end else begin
			rd_host <= host.gnt && !host.we;
			rd_lsu <= lsu.gnt && !lsu.we;
			rd_fetch <= fetch.gnt && !fetch.we;
		end
	end

	assign host.rvalid = rd_host;
	assign lsu.rvalid = rd_lsu;
	assign fetch.rvalid = rd_fetch;
	assign host.rdata = mem_rdata;
	assign lsu.rdata = mem_rdata;
	assign fetch.rdata = mem_rdata;

endmodule

// File: logic/unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 32
) (
	input logic clk,
	input logic en,
	input logic we,
	input logic [ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// Read data holds until the next enabled read
	always_ff @(posedge clk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

// File: logic/arm_core_top.sv
`timescale 1ns/1ps

module arm_core_top import arm_pkg::*; #(
	parameter int ADDR_W = arm_pkg::ADDR_W
) (
	input logic clk,
	input logic rst_n,
	input logic run,
	output logic halted,
	output logic [3:0] status,
	input logic host_req,
	input logic host_we,
	input logic [ADDR_W-1:0] host_addr,
	input logic [DATA_W-1:0] host_wdata,
	output logic host_gnt,
	output logic host_rvalid,
	output logic [DATA_W-1:0] host_rdata
);

	instr_u instr;
	exe_cmd_e exe_cmd;
	flags_t flags;
	logic immediate;
	logic mem_read;
	logic mem_write;
	logic wb_enable;
	logic branch_taken;
	logic status_write_enable;
	logic lsu_start;
	logic lsu_done;
	logic wb_sel_load;
	logic reg_we;
	logic flag_we;
	logic [DATA_W-1:0] load_data;
	logic [DATA_W-1:0] alu_result;
	logic [DATA_W-1:0] rdata_a;
	logic [DATA_W-1:0] rdata_b;
	logic mem_en;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata;

	mem_bus_if #(.ADDR_W(ADDR_W)) fetch_bus ();
	mem_bus_if #(.ADDR_W(ADDR_W)) lsu_bus ();
	mem_bus_if #(.ADDR_W(ADDR_W)) host_bus ();

	assign host_bus.req = host_req;
	assign host_bus.we = host_we;
	assign host_bus.addr = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_gnt = host_bus.gnt;
	assign host_rvalid = host_bus.rvalid;
	assign host_rdata = host_bus.rdata;
	assign status = flags;

	instr_sequencer #(.ADDR_W(ADDR_W)) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.bus(fetch_bus),
		.instr(instr),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.wb_enable(wb_enable),
		.branch_taken(branch_taken),
		.status_write_enable(status_write_enable),
		.lsu_start(lsu_start),
		.lsu_done(lsu_done),
		.wb_sel_load(wb_sel_load),
		.reg_we(reg_we),
		.flag_we(flag_we),
		.halted(halted)
	);

	control_unit u_ctrl (
		.instr(instr),
		.exe_cmd(exe_cmd),
		.immediate(immediate),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.wb_enable(wb_enable),
		.branch_taken(branch_taken),
		.status_write_enable(status_write_enable)
	);

	// A store reads its data register on port B, its offset is the immediate
	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.rs_a(instr.dp.rn),
		.rs_b(mem_write ? instr.dp.rd : instr.dp.op2[3:0]),
		.rd(instr.dp.rd),
		.we(reg_we),
		.wdata(wb_sel_load ? load_data : alu_result),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	execute_unit u_exe (
		.clk(clk),
		.rst_n(rst_n),
		.exe_cmd(exe_cmd),
		.op_a(rdata_a),
		.op_b(immediate ? DATA_W'(instr.dp.op2) : rdata_b),
		.flag_we(flag_we),
		.result(alu_result),
		.flags(flags)
	);

	load_store_unit #(.ADDR_W(ADDR_W)) u_lsu (
		.clk(clk),
		.rst_n(rst_n),
		.start(lsu_start),
		.is_load(mem_read),
		.addr(alu_result[ADDR_W-1:0]),
		.store_data(rdata_b),
		.bus(lsu_bus),
		.done(lsu_done),
		.load_data(load_data)
	);

	mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
		.clk(clk),
		.rst_n(rst_n),
		.host(host_bus),
		.lsu(lsu_bus),
		.fetch(fetch_bus),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	unified_memory #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem (
		.clk(clk),
		.en(mem_en),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

// File: testbench/tb_arm_core.sv
`timescale 1ns/1ps

module tb_arm_core import arm_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int TB_ADDR_W = 8;

	logic clk;
	logic rst_n;
	logic run;
	logic halted;
	logic [3:0] status;
	logic host_req;
	logic host_we;
	logic [TB_ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic host_gnt;
	logic host_rvalid;
	logic [DATA_W-1:0] host_rdata;

	integer seed;
	int errors;
	logic [31:0] prog [64];
	int prog_len;
	flags_t model_flags;

	arm_core_top #(.ADDR_W(TB_ADDR_W)) uut (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.halted(halted),
		.status(status),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_gnt(host_gnt),
		.host_rvalid(host_rvalid),
		.host_rdata(host_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", test, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [31:0] dp_instr(input opcode_e op, input logic s, input logic imm,
			input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] op2);
		instr_u w;
		w = '0;
		w.dp.mode = MODE_ARITH;
		w.dp.imm = imm;
		w.dp.opcode = op;
		w.dp.s = s;
		w.dp.rn = rn;
		w.dp.rd = rd;
		w.dp.op2 = op2;
		return w;
	endfunction

	// Loads and stores address rn plus an immediate offset
	function automatic logic [31:0] mem_instr(input logic load, input logic [3:0] rn,
			input logic [3:0] rd, input logic [11:0] offset);
		instr_u w;
		w = '0;
		w.dp.mode = MODE_MEMORY;
		w.dp.imm = 1'b1;
		w.dp.s = load;
		w.dp.rn = rn;
		w.dp.rd = rd;
		w.dp.op2 = offset;
		return w;
	endfunction

	function automatic logic [31:0] branch_instr(input int offset);
		instr_u w;
		w = '0;
		w.br.mode = MODE_BRANCH;
		w.br.offset = 24'(offset);
		return w;
	endfunction

	function automatic logic [31:0] halt_instr();
		instr_u w;
		w = '0;
		w.dp.mode = MODE_HALT;
		return w;
	endfunction

	// Result in the low word with NZCV above it
	function automatic logic [35:0] model_op(input opcode_e op, input logic [31:0] a,
			input logic [31:0] b, input flags_t f);
		logic [31:0] r;
		logic [32:0] wide;
		logic borrow;
		flags_t nf;
		nf = f;
		r = '0;
		case (op)
			OP_ADD, OP_ADC: begin
				wide = {1'b0, a} + {1'b0, b} + ((op == OP_ADC) ? f.c : 1'b0);
				r = wide[31:0];
				nf.c = wide[32];
				nf.v = (a[31] == b[31]) && (r[31] != a[31]);
			end
			OP_SUB, OP_SBC, OP_CMP: begin
				borrow = (op == OP_SBC) ? !f.c : 1'b0;
				r = a - b - borrow;
				// C means no borrow was taken
				nf.c = ({1'b0, a} >= {1'b0, b} + borrow);
				nf.v = (a[31] != b[31]) && (r[31] != a[31]);
			end
			OP_AND, OP_TST: r = a & b;
			OP_ORR: r = a | b;
			OP_EOR: r = a ^ b;
			OP_MOV: r = b;
			OP_MVN: r = ~b;
			default: r = '0;
		endcase
		nf.n = r[31];
		nf.z = (r == 32'd0);
		return {nf, r};
	endfunction

	task automatic model_step(input opcode_e op, input logic s, input logic [31:0] a,
			input logic [31:0] b, output logic [31:0] r);
		logic [35:0] out;
		out = model_op(op, a, b, model_flags);
		if (s || op == OP_CMP || op == OP_TST)
			model_flags = out[35:32];
		r = out[31:0];
	endtask

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b1;
		host_addr <= addr;
		host_wdata <= data;
		do @(posedge clk); while (!host_gnt);
		host_req <= 1'b0;
		host_we <= 1'b0;
	endtask

	task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= 1'b0;
		host_addr <= addr;
		do @(posedge clk); while (!host_gnt);
		host_req <= 1'b0;
		@(posedge clk);
		if (!host_rvalid) begin
			$display("Host read of address %0d got no rvalid one cycle after its grant", addr);
			errors++;
		end
		data = host_rdata;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_len; i++)
			host_write(8'(i), prog[i]);
	endtask

	task automatic run_program(input string test);
		@(posedge clk);
		run <= 1'b1;
		do @(posedge clk); while (!halted);
		repeat (3) begin
			@(posedge clk);
			check_value({test, " halt hold"}, 32'd1, halted);
		end
		run <= 1'b0;
		do @(posedge clk); while (halted);
	endtask

	task automatic host_port_test();
		logic [7:0] addrs [8];
		logic [31:0] data [8];
		logic [31:0] got;
		for (int i = 0; i < 8; i++) begin
			addrs[i] = {3'(i), 5'($random(seed))};
			data[i] = $random(seed);
			host_write(addrs[i], data[i]);
		end
		// Rewrite one address so its read must return the newer word
		data[3] = $random(seed);
		host_write(addrs[3], data[3]);
		for (int i = 0; i < 8; i++) begin
			host_read(addrs[i], got);
			check_value("host port", data[i], got);
		end
	endtask

	task automatic data_processing_test();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		logic [31:0] expected [7];
		logic [31:0] got;
		a = $random(seed);
		b = $random(seed);
		imm_a = 12'($random(seed));
		imm_b = 12'($random(seed));
		host_write(8'h80, a);
		host_write(8'h81, b);
		prog_len = 0;
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h080));
		emit(mem_instr(1'b1, 4'd1, 4'd2, 12'd0));
		emit(mem_instr(1'b1, 4'd1, 4'd3, 12'd1));
		emit(dp_instr(OP_ADD, 1'b0, 1'b0, 4'd2, 4'd4, 12'd3));
		emit(dp_instr(OP_SUB, 1'b0, 1'b0, 4'd2, 4'd5, 12'd3));
		emit(dp_instr(OP_AND, 1'b0, 1'b0, 4'd2, 4'd6, 12'd3));
		emit(dp_instr(OP_ORR, 1'b0, 1'b0, 4'd2, 4'd7, 12'd3));
		emit(dp_instr(OP_EOR, 1'b0, 1'b0, 4'd2, 4'd8, 12'd3));
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd9, imm_a));
		emit(dp_instr(OP_MVN, 1'b0, 1'b1, 4'd0, 4'd10, imm_b));
		for (int k = 0; k < 7; k++)
			emit(mem_instr(1'b0, 4'd1, 4'(k + 4), 12'(k + 2)));
		emit(halt_instr());
		model_step(OP_ADD, 1'b0, a, b, expected[0]);
		model_step(OP_SUB, 1'b0, a, b, expected[1]);
		model_step(OP_AND, 1'b0, a, b, expected[2]);
		model_step(OP_ORR, 1'b0, a, b, expected[3]);
		model_step(OP_EOR, 1'b0, a, b, expected[4]);
		model_step(OP_MOV, 1'b0, 32'd0, {20'd0, imm_a}, expected[5]);
		model_step(OP_MVN, 1'b0, 32'd0, {20'd0, imm_b}, expected[6]);
		load_program();
		run_program("data processing");
		for (int k = 0; k < 7; k++) begin
			host_read(8'(8'h82 + k), got);
			check_value("data processing", expected[k], got);
		end
	endtask

	task automatic flags_test();
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] r;
		x = $random(seed);
		y = $random(seed);
		host_write(8'h80, x);
		host_write(8'h81, 32'h8000_0000);
		host_write(8'h82, 32'h0000_0001);
		host_write(8'h83, y);
		prog_len = 0;
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h080));
		emit(mem_instr(1'b1, 4'd1, 4'd2, 12'd0));
		emit(mem_instr(1'b1, 4'd1, 4'd3, 12'd1));
		emit(mem_instr(1'b1, 4'd1, 4'd4, 12'd2));
		emit(mem_instr(1'b1, 4'd1, 4'd7, 12'd3));
		emit(dp_instr(OP_CMP, 1'b1, 1'b0, 4'd2, 4'd0, 12'd2));
		emit(dp_instr(OP_ADD, 1'b0, 1'b0, 4'd2, 4'd5, 12'd7));
		emit(halt_instr());
		model_step(OP_CMP, 1'b1, x, x, r);
		model_step(OP_ADD, 1'b0, x, y, r);
		load_program();
		run_program("flags cmp");
		check_value("flags cmp zc", 32'd3, status[2:1]);
		check_value("flags cmp", model_flags, status);
		// Registers survive between runs so r3 and r4 still hold the operands
		prog_len = 0;
		emit(dp_instr(OP_SUB, 1'b1, 1'b0, 4'd3, 4'd6, 12'd4));
		emit(halt_instr());
		model_step(OP_SUB, 1'b1, 32'h8000_0000, 32'h0000_0001, r);
		load_program();
		run_program("flags overflow");
		check_value("flags overflow v", 32'd1, status[0]);
		check_value("flags overflow", model_flags, status);
		prog_len = 0;
		emit(dp_instr(OP_TST, 1'b1, 1'b0, 4'd2, 4'd0, 12'd7));
		emit(halt_instr());
		model_step(OP_TST, 1'b1, x, y, r);
		load_program();
		run_program("flags tst");
		check_value("flags tst cv", 32'd3, status[1:0]);
		check_value("flags tst", model_flags, status);
	endtask

	task automatic carry_chain_test();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] sum;
		logic [63:0] diff;
		logic [31:0] expected [4];
		logic [31:0] r;
		logic [31:0] got;
		a = {$random(seed), $random(seed) | 32'h8000_0000};
		b = {$random(seed), $random(seed) | 32'h8000_0000};
		sum = a + b;
		diff = a - b;
		expected[0] = sum[31:0];
		expected[1] = sum[63:32];
		expected[2] = diff[31:0];
		expected[3] = diff[63:32];
		host_write(8'h80, a[31:0]);
		host_write(8'h81, a[63:32]);
		host_write(8'h82, b[31:0]);
		host_write(8'h83, b[63:32]);
		prog_len = 0;
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h080));
		for (int k = 0; k < 4; k++)
			emit(mem_instr(1'b1, 4'd1, 4'(k + 2), 12'(k)));
		emit(dp_instr(OP_ADD, 1'b1, 1'b0, 4'd2, 4'd6, 12'd4));
		emit(dp_instr(OP_ADC, 1'b0, 1'b0, 4'd3, 4'd7, 12'd5));
		emit(dp_instr(OP_SUB, 1'b1, 1'b0, 4'd2, 4'd8, 12'd4));
		emit(dp_instr(OP_SBC, 1'b0, 1'b0, 4'd3, 4'd9, 12'd5));
		for (int k = 0; k < 4; k++)
			emit(mem_instr(1'b0, 4'd1, 4'(k + 6), 12'(k + 4)));
		emit(halt_instr());
		model_step(OP_ADD, 1'b1, a[31:0], b[31:0], r);
		model_step(OP_ADC, 1'b0, a[63:32], b[63:32], r);
		model_step(OP_SUB, 1'b1, a[31:0], b[31:0], r);
		model_step(OP_SBC, 1'b0, a[63:32], b[63:32], r);
		load_program();
		run_program("carry chain");
		check_value("carry chain flags", model_flags, status);
		for (int k = 0; k < 4; k++) begin
			host_read(8'(8'h84 + k), got);
			check_value("carry chain", expected[k], got);
		end
	endtask

	task automatic load_store_test();
		logic [31:0] d;
		logic [11:0] imm;
		logic [31:0] sum;
		logic [31:0] got;
		d = $random(seed);
		imm = 12'($random(seed));
		host_write(8'h90, d);
		prog_len = 0;
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h090));
		emit(mem_instr(1'b1, 4'd1, 4'd2, 12'd0));
		emit(dp_instr(OP_ADD, 1'b0, 1'b1, 4'd2, 4'd3, imm));
		emit(mem_instr(1'b0, 4'd1, 4'd3, 12'd1));
		emit(mem_instr(1'b0, 4'd1, 4'd2, 12'd2));
		emit(mem_instr(1'b0, 4'd1, 4'd3, 12'd3));
		emit(halt_instr());
		model_step(OP_ADD, 1'b0, d, {20'd0, imm}, sum);
		load_program();
		// Host reads compete with fetch and load/store for the memory
		fork
			run_program("load/store");
			begin
				repeat (6) begin
					host_read(8'h90, got);
					check_value("load/store host read", d, got);
				end
			end
		join
		host_read(8'h91, got);
		check_value("load/store modify", sum, got);
		host_read(8'h92, got);
		check_value("load/store loaded", d, got);
		host_read(8'h93, got);
		check_value("load/store rd kept", sum, got);
	endtask

	task automatic branch_test();
		logic [31:0] marker;
		int n;
		logic [31:0] got;
		marker = $random(seed);
		n = 3 + ($random(seed) & 7);
		host_write(8'hA0, marker);
		host_write(8'hA2, halt_instr());
		prog_len = 0;
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd1, 12'h0A0));
		emit(mem_instr(1'b1, 4'd1, 4'd6, 12'd2));
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd2, 12'd0));
		// Loop branch sits at word 10 and pass n writes HALT over it
		emit(dp_instr(OP_MOV, 1'b0, 1'b1, 4'd0, 4'd4, 12'(10 + n)));
		emit(branch_instr(1));
		emit(mem_instr(1'b0, 4'd1, 4'd1, 12'd0));
		emit(dp_instr(OP_ADD, 1'b0, 1'b1, 4'd2, 4'd2, 12'd1));
		emit(dp_instr(OP_SUB, 1'b0, 1'b0, 4'd4, 4'd5, 12'd2));
		emit(mem_instr(1'b0, 4'd5, 4'd6, 12'd0));
		emit(mem_instr(1'b0, 4'd1, 4'd2, 12'd1));
		emit(branch_instr(-5));
		load_program();
		run_program("branch");
		host_read(8'hA0, got);
		check_value("branch marker", marker, got);
		host_read(8'hA1, got);
		check_value("branch loop count", 32'(n), got);
	endtask

	initial begin
		seed = 32'h71b8ad8a;
		errors = 0;
		prog_len = 0;
		model_flags = '0;
		rst_n = 1'b0;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_value("reset halted", 32'd0, halted);
		check_value("reset status", 32'd0, status);
		check_value("reset host_gnt", 32'd0, host_gnt);
		check_value("reset host_rvalid", 32'd0, host_rvalid);
		host_port_test();
		data_processing_test();
		flags_test();
		carry_chain_test();
		load_store_test();
		branch_test();
		$display("Tests finished with %0d errors", errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 2000);
		$display("Test failed");
		$finish;
	end

endmodule

// File: src.f
logic/arm_pkg.sv
logic/mem_bus_if.sv
logic/control_unit.sv
logic/execute_unit.sv
logic/register_file.sv
logic/instr_sequencer.sv
logic/load_store_unit.sv
logic/mem_arbiter.sv
logic/unified_memory.sv
logic/arm_core_top.sv
testbench/tb_arm_core.sv

// File: Bender.yml
package:
  name: arm_core

sources:
  - logic/arm_pkg.sv
  - logic/mem_bus_if.sv
  - logic/control_unit.sv
  - logic/execute_unit.sv
  - logic/register_file.sv
  - logic/instr_sequencer.sv
  - logic/load_store_unit.sv
  - logic/mem_arbiter.sv
  - logic/unified_memory.sv
  - logic/arm_core_top.sv
  - target: test
    files:
      - testbench/tb_arm_core.sv
